// ==== common/cpu_pkg.sv ====
package cpu_pkg;

	// width of a data word and of a byte address
	localparam int word_w = 16;
	// sixteen registers
	localparam int reg_addr_w = 4;
	// word address bits of each memory, 1024 words
	localparam int mem_addr_w = 10;

	// alu operation that computes nothing and writes no flag
	// the decoder sends it for every non-alu instruction
	localparam logic [2:0] alu_nop = 3'b111;

	// values 3 and 7 are reserved and decode as no-operations
	typedef enum logic [3:0] {
		op_add = 4'h0,
		op_sub = 4'h1,
		op_xor = 4'h2,
		op_sll = 4'h4,
		op_sra = 4'h5,
		op_ror = 4'h6,
		op_lw  = 4'h8,
		op_sw  = 4'h9,
		op_llb = 4'ha,
		op_lhb = 4'hb,
		op_b   = 4'hc,
		op_br  = 4'hd,
		op_pcs = 4'he,
		op_hlt = 4'hf
	} opcode_e;

	// branch conditions, checked against the stored flags
	typedef enum logic [2:0] {
		cond_ne     = 3'd0,
		cond_eq     = 3'd1,
		cond_gt     = 3'd2,
		cond_lt     = 3'd3,
		cond_ge     = 3'd4,
		cond_le     = 3'd5,
		cond_ovf    = 3'd6,
		cond_always = 3'd7
	} cond_e;

	// flag write enables use the same bit order
	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	// alu, memory and pcs format
	typedef struct packed {
		opcode_e opcode;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
	} rtype_t;

	// llb and lhb format
	typedef struct packed {
		opcode_e opcode;
		logic [reg_addr_w-1:0] rd;
		logic [7:0] imm8;
	} byte_t;

	// b and br format
	typedef struct packed {
		opcode_e opcode;
		cond_e cond;
		logic [8:0] offset9;
	} branch_t;

	typedef union packed {
		rtype_t rtype;
		byte_t bytes;
		branch_t branch;
	} instr_t;

endpackage

// ==== alu/alu.sv ====
module alu import cpu_pkg::*; (
	input  logic [word_w-1:0] a,
	input  logic [word_w-1:0] b,
	input  logic [2:0] op,
	output logic [word_w-1:0] result,
	output flags_t flags,
	output logic [2:0] flags_wen
);

	logic [word_w-1:0] sum;
	logic [word_w-1:0] diff;
	logic add_ovf;
	logic sub_ovf;
	// clamp value, follows the sign of a on overflow
	logic [word_w-1:0] sat_val;
	logic [3:0] shamt;
	// two copies of a so a right shift rotates
	logic [2*word_w-1:0] rot;

	assign sum = a + b;
	assign diff = a - b;

	// same-sign operands with a result of the other sign
	assign add_ovf = (a[word_w-1] == b[word_w-1]) && (sum[word_w-1] != a[word_w-1]);
	// subtract overflows only when the operand signs differ
	assign sub_ovf = (a[word_w-1] != b[word_w-1]) && (diff[word_w-1] != a[word_w-1]);

	assign sat_val = a[word_w-1] ? {1'b1, {(word_w-1){1'b0}}} : {1'b0, {(word_w-1){1'b1}}};

	assign shamt = b[3:0];
	assign rot = {a, a} >> shamt;

	always_comb begin
		result = '0;
		flags_wen = 3'b000;
		flags.v = 1'b0;
		case (op)
			// add
			3'b000: begin
				result = add_ovf ? sat_val : sum;
				flags.v = add_ovf;
				flags_wen = 3'b111;
			end
			// sub
			3'b001: begin
				result = sub_ovf ? sat_val : diff;
				flags.v = sub_ovf;
				flags_wen = 3'b111;
			end
			// xor
			3'b010: begin
				result = a ^ b;
				flags_wen = 3'b100;
			end
			// sll
			3'b100: begin
				result = a << shamt;
				flags_wen = 3'b100;
			end
			// sra keeps the sign bit
			3'b101: begin
				result = $signed(a) >>> shamt;
				flags_wen = 3'b100;
			end
			// ror
			3'b110: begin
				result = rot[word_w-1:0];
				flags_wen = 3'b100;
			end
			// alu_nop and reserved codes leave the flags alone
			default: begin
			end
		endcase
		flags.z = (result == '0);
		flags.n = result[word_w-1];
	end

endmodule

// ==== hdl/memory.sv ====
module memory import cpu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic [word_w-1:0] addr,
	input  logic wen,
	input  logic [word_w-1:0] wdata,
	output logic [word_w-1:0] rdata
);

	logic [word_w-1:0] mem [2**mem_addr_w];
	// byte address to word index, bit 0 dropped
	logic [mem_addr_w-1:0] word_addr;

	assign word_addr = addr[mem_addr_w:1];

	// combinational read
	assign rdata = mem[word_addr];

	// write at the edge
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[word_addr] <= wdata;
		end
	end

	// upper address bits must be clear or the store would alias
	assert property (@(posedge clk) disable iff (rst)
		wen |-> addr[word_w-1:mem_addr_w+1] == '0)
		else $error("store outside memory range");

endmodule

// ==== hdl/register_file.sv ====
module register_file import cpu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic [reg_addr_w-1:0] src1,
	input  logic [reg_addr_w-1:0] src2,
	input  logic [reg_addr_w-1:0] dst,
	input  logic wen,
	input  logic [word_w-1:0] wdata,
	output logic [word_w-1:0] rdata1,
	output logic [word_w-1:0] rdata2
);

	logic [word_w-1:0] regs [2**reg_addr_w];

	// one write port, all registers clear on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (wen) begin
			regs[dst] <= wdata;
		end
	end

	// asynchronous reads
	// a write lands at the edge so the next instruction reads it
	// forwarding wdata here would close a loop through the alu
	// since wdata is built from these same reads in one cycle
	assign rdata1 = regs[src1];
	assign rdata2 = regs[src2];

endmodule

// ==== hdl/control_unit.sv ====
module control_unit import cpu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  instr_t instr,
	output logic reg_write,
	output logic mem_read,
	output logic mem_write,
	output logic mem_to_reg,
	output logic alu_src_imm,
	output logic [2:0] alu_op,
	output logic top_half,
	output logic is_pcs,
	output logic is_branch,
	output logic is_branch_reg,
	output logic read_rd,
	output logic hlt
);

	// set once hlt has been seen, only rst clears it
	logic halted;

	always_ff @(posedge clk) begin
		if (rst) begin
			halted <= 1'b0;
		end else if (instr.rtype.opcode == op_hlt) begin
			halted <= 1'b1;
		end
	end

	// high in the hlt cycle itself
	assign hlt = halted | (instr.rtype.opcode == op_hlt);

	always_comb begin
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_to_reg = 1'b0;
		alu_src_imm = 1'b0;
		alu_op = alu_nop;
		top_half = 1'b0;
		is_pcs = 1'b0;
		is_branch = 1'b0;
		is_branch_reg = 1'b0;
		read_rd = 1'b0;
		// halted core drives nothing, reserved opcodes fall to default
		if (!halted) begin
			case (instr.rtype.opcode)
				op_add, op_sub, op_xor: begin
					reg_write = 1'b1;
					alu_op = instr.rtype.opcode[2:0];
				end
				op_sll, op_sra, op_ror: begin
					reg_write = 1'b1;
					alu_src_imm = 1'b1;
					alu_op = instr.rtype.opcode[2:0];
				end
				op_lw: begin
					reg_write = 1'b1;
					mem_read = 1'b1;
					mem_to_reg = 1'b1;
				end
				op_sw: begin
					mem_write = 1'b1;
					read_rd = 1'b1;
				end
				op_llb: begin
					reg_write = 1'b1;
					read_rd = 1'b1;
				end
				op_lhb: begin
					reg_write = 1'b1;
					read_rd = 1'b1;
					top_half = 1'b1;
				end
				op_b: is_branch = 1'b1;
				op_br: begin
					is_branch_reg = 1'b1;
					read_rd = 1'b1;
				end
				op_pcs: begin
					reg_write = 1'b1;
					is_pcs = 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

	// a halted core holds pc, so the fetched word stays hlt
	assert property (@(posedge clk) disable iff (rst)
		halted |-> instr.rtype.opcode == op_hlt)
		else $error("halted core fetched a word other than hlt");

endmodule

// ==== hdl/pc_control.sv ====
module pc_control import cpu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  instr_t instr,
	input  logic [word_w-1:0] branch_target_reg,
	input  logic stall,
	input  flags_t flags_new,
	input  logic [2:0] flags_wen,
	output logic [word_w-1:0] pc
);

	// flags from the last alu instruction that wrote them
	flags_t flags;
	logic cond_met;
	logic [word_w-1:0] pc_plus2;
	logic [word_w-1:0] branch_target;
	logic [word_w-1:0] pc_next;

	// branch condition against the stored flags
	always_comb begin
		case (instr.branch.cond)
			cond_ne:  cond_met = !flags.z;
			cond_eq:  cond_met = flags.z;
			cond_gt:  cond_met = !flags.z && !flags.n;
			cond_lt:  cond_met = flags.n;
			cond_ge:  cond_met = flags.z || (!flags.z && !flags.n);
			cond_le:  cond_met = flags.n || flags.z;
			cond_ovf: cond_met = flags.v;
			default:  cond_met = 1'b1;
		endcase
	end

	assign pc_plus2 = pc + word_w'(2);
	// offset counts words so shift left by one
	assign branch_target = pc_plus2
		+ {{(word_w-10){instr.branch.offset9[8]}}, instr.branch.offset9, 1'b0};

	// next pc select
	always_comb begin
		pc_next = pc_plus2;
		if (stall) begin
			// halted, stay on the hlt word
			pc_next = pc;
		end else if (cond_met && instr.branch.opcode == op_b) begin
			pc_next = branch_target;
		end else if (cond_met && instr.branch.opcode == op_br) begin
			pc_next = branch_target_reg;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			flags <= '0;
		end else begin
			pc <= pc_next;
			// each flag updates on its own enable
			if (!stall) begin
				if (flags_wen[2]) begin
					flags.z <= flags_new.z;
				end
				if (flags_wen[1]) begin
					flags.v <= flags_new.v;
				end
				if (flags_wen[0]) begin
					flags.n <= flags_new.n;
				end
			end
		end
	end

	// instructions are word aligned, so every target must be too
	assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
		else $error("pc is odd");

endmodule

// ==== hdl/cpu.sv ====
module cpu import cpu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic prog_we,
	input  logic [word_w-1:0] prog_addr,
	input  logic [word_w-1:0] prog_data,
	output logic hlt,
	output logic [word_w-1:0] pc,
	output logic reg_wen,
	output logic [reg_addr_w-1:0] reg_dst,
	output logic [word_w-1:0] reg_wdata,
	output logic mem_wen,
	output logic [word_w-1:0] mem_addr,
	output logic [word_w-1:0] mem_wdata
);

	// fetched word, seen through the three instruction views
	instr_t instr;
	logic [word_w-1:0] imem_rdata;
	logic [word_w-1:0] imem_addr;
	logic imem_wen;

	// decoder outputs
	logic mem_read;
	logic mem_to_reg;
	logic alu_src_imm;
	logic [2:0] alu_op;
	logic top_half;
	logic is_pcs;
	logic is_branch;
	logic is_branch_reg;
	logic read_rd;

	// register file
	logic [reg_addr_w-1:0] src2;
	logic [word_w-1:0] rdata1;
	logic [word_w-1:0] rdata2;

	// execute
	logic [word_w-1:0] alu_b;
	logic [word_w-1:0] alu_result;
	flags_t alu_flags;
	logic [2:0] alu_flags_wen;
	logic [word_w-1:0] dmem_rdata;
	logic [word_w-1:0] byte_merged;
	logic [word_w-1:0] pc_plus2;
	logic byte_sel;

	// program load owns the instruction memory while in reset
	assign imem_addr = rst ? prog_addr : pc;
	assign imem_wen = prog_we & rst;
	assign instr = imem_rdata;

	memory imem (
		.clk(clk),
		.rst(rst),
		.addr(imem_addr),
		.wen(imem_wen),
		.wdata(prog_data),
		.rdata(imem_rdata)
	);

	control_unit ctrl (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.reg_write(reg_wen),
		.mem_read(mem_read),
		.mem_write(mem_wen),
		.mem_to_reg(mem_to_reg),
		.alu_src_imm(alu_src_imm),
		.alu_op(alu_op),
		.top_half(top_half),
		.is_pcs(is_pcs),
		.is_branch(is_branch),
		.is_branch_reg(is_branch_reg),
		.read_rd(read_rd),
		.hlt(hlt)
	);

	// sw, llb, lhb and br need rd on the second port
	assign src2 = read_rd ? instr.rtype.rd : instr.rtype.rt;
	assign reg_dst = instr.rtype.rd;

	register_file regs (
		.clk(clk),
		.rst(rst),
		.src1(instr.rtype.rs),
		.src2(src2),
		.dst(reg_dst),
		.wen(reg_wen),
		.wdata(reg_wdata),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	// shift amount is the unsigned imm4
	assign alu_b = alu_src_imm ? {{(word_w-4){1'b0}}, instr.rtype.rt} : rdata2;

	alu alu_i (
		.a(rdata1),
		.b(alu_b),
		.op(alu_op),
		.result(alu_result),
		.flags(alu_flags),
		.flags_wen(alu_flags_wen)
	);

	// base plus sign-extended word offset
	assign mem_addr = rdata1 + {{(word_w-5){instr.rtype.rt[3]}}, instr.rtype.rt, 1'b0};
	assign mem_wdata = rdata2;

	memory dmem (
		.clk(clk),
		.rst(rst),
		.addr(mem_addr),
		.wen(mem_wen),
		.wdata(mem_wdata),
		.rdata(dmem_rdata)
	);

	pc_control pcu (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.branch_target_reg(rdata1),
		.stall(hlt),
		.flags_new(alu_flags),
		.flags_wen(alu_flags_wen),
		.pc(pc)
	);

	// only llb and lhb both read rd and write a register
	assign byte_sel = read_rd & reg_wen;
	assign byte_merged = top_half ? {instr.bytes.imm8, rdata2[7:0]}
		: {rdata2[15:8], instr.bytes.imm8};
	assign pc_plus2 = pc + word_w'(2);

	// write-back select
	assign reg_wdata = is_pcs ? pc_plus2
		: mem_to_reg ? dmem_rdata
		: byte_sel ? byte_merged
		: alu_result;

	// loading a program outside reset is dropped
	assert property (@(posedge clk) prog_we |-> rst)
		else $error("program write while rst is low");

	// anything that is not a branch or a halt falls through to pc + 2
	assert property (@(posedge clk) disable iff (rst)
		!(is_branch || is_branch_reg || hlt) |=> pc == $past(pc) + word_w'(2))
		else $error("pc left sequential order without a branch");

	// a load must hit a word that an earlier store wrote
	assert property (@(posedge clk) disable iff (rst) mem_read |-> !$isunknown(dmem_rdata))
		else $error("load from an unwritten data word");

endmodule

// ==== verification/cpu_tb.sv ====
module cpu_tb import cpu_pkg::*; ();

	logic clk;
	logic rst;
	logic prog_we;
	logic [word_w-1:0] prog_addr;
	logic [word_w-1:0] prog_data;
	logic hlt;
	logic [word_w-1:0] pc;
	logic reg_wen;
	logic [reg_addr_w-1:0] reg_dst;
	logic [word_w-1:0] reg_wdata;
	logic mem_wen;
	logic [word_w-1:0] mem_addr;
	logic [word_w-1:0] mem_wdata;

	// program words from the P records
	logic [word_w-1:0] p_addr [$];
	logic [word_w-1:0] p_data [$];

	// one expected trace per cycle from the E records
	logic [word_w-1:0] e_pc [$];
	logic [word_w-1:0] e_hlt [$];
	logic [word_w-1:0] e_reg_wen [$];
	logic [word_w-1:0] e_reg_dst [$];
	logic [word_w-1:0] e_reg_wdata [$];
	logic [word_w-1:0] e_mem_wen [$];
	logic [word_w-1:0] e_mem_addr [$];
	logic [word_w-1:0] e_mem_wdata [$];

	// watchdog waits for the record count
	logic cases_read = 1'b0;
	int watchdog_cycles = 0;

	cpu dut (
		.clk(clk),
		.rst(rst),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.hlt(hlt),
		.pc(pc),
		.reg_wen(reg_wen),
		.reg_dst(reg_dst),
		.reg_wdata(reg_wdata),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_value(input string name, input int idx,
		input logic [word_w-1:0] got, input logic [word_w-1:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("ERROR: %s in record %0d is %h, expected %h",
				name, idx, got, exp));
		end
	endtask

	// parse the case file into the queues, up to the END marker
	task automatic read_cases();
		int fd;
		int code;
		int c;
		logic done;
		string kind;
		logic [word_w-1:0] f0;
		logic [word_w-1:0] f1;
		logic [word_w-1:0] f2;
		logic [word_w-1:0] f3;
		logic [word_w-1:0] f4;
		logic [word_w-1:0] f5;
		logic [word_w-1:0] f6;
		logic [word_w-1:0] f7;
		done = 1'b0;
		fd = $fopen("verification/cpu_cases.mem", "r");
		if (fd == 0) begin
			stop_with_failure("could not open verification/cpu_cases.mem");
		end
		while (!done) begin
			code = $fscanf(fd, "%s", kind);
			if (code != 1) begin
				stop_with_failure("case file ended before its END marker");
			end else if (kind.getc(0) == "#") begin
				// comment runs to the end of the line
				c = $fgetc(fd);
				while (c != 10 && c != -1) begin
					c = $fgetc(fd);
				end
			end else if (kind == "P") begin
				code = $fscanf(fd, "%h %h", f0, f1);
				if (code != 2) begin
					stop_with_failure("malformed program record in case file");
				end else begin
					p_addr.push_back(f0);
					p_data.push_back(f1);
				end
			end else if (kind == "E") begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6, f7);
				if (code != 8) begin
					stop_with_failure("malformed expected record in case file");
				end else begin
					e_pc.push_back(f0);
					e_hlt.push_back(f1);
					e_reg_wen.push_back(f2);
					e_reg_dst.push_back(f3);
					e_reg_wdata.push_back(f4);
					e_mem_wen.push_back(f5);
					e_mem_addr.push_back(f6);
					e_mem_wdata.push_back(f7);
				end
			end else if (kind == "END") begin
				done = 1'b1;
			end else begin
				stop_with_failure($sformatf("unknown record kind %s in case file", kind));
			end
		end
		$fclose(fd);
		if (p_addr.size() == 0 || e_pc.size() == 0) begin
			stop_with_failure("case file holds no program or no expected records");
		end
	endtask

	// trace fields only count while their enable is expected high
	task automatic check_record(input int idx);
		compare_value("pc", idx, pc, e_pc[idx]);
		compare_value("hlt", idx, word_w'(hlt), e_hlt[idx]);
		compare_value("reg_wen", idx, word_w'(reg_wen), e_reg_wen[idx]);
		if (e_reg_wen[idx] != '0) begin
			compare_value("reg_dst", idx, word_w'(reg_dst), e_reg_dst[idx]);
			compare_value("reg_wdata", idx, reg_wdata, e_reg_wdata[idx]);
		end
		compare_value("mem_wen", idx, word_w'(mem_wen), e_mem_wen[idx]);
		if (e_mem_wen[idx] != '0) begin
			compare_value("mem_addr", idx, mem_addr, e_mem_addr[idx]);
			compare_value("mem_wdata", idx, mem_wdata, e_mem_wdata[idx]);
		end
	endtask

	// load time plus one cycle per record plus margin
	initial begin
		wait (cases_read);
		#(watchdog_cycles * 100);
		stop_with_failure("timeout, the run did not finish in time");
	end

	initial begin : main
		int reset_cycles;
		rst = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		read_cases();
		watchdog_cycles = p_addr.size() + 4 + e_pc.size() + 20;
		cases_read = 1'b1;

		// one program word per edge while rst is high
		reset_cycles = 0;
		for (int i = 0; i < p_addr.size(); i++) begin
			@(posedge clk);
			prog_we <= 1'b1;
			prog_addr <= p_addr[i];
			prog_data <= p_data[i];
			reset_cycles++;
		end
		// reset lasts at least 4 cycles
		while (reset_cycles < 4) begin
			@(posedge clk);
			prog_we <= 1'b0;
			reset_cycles++;
		end
		// the last word lands on this edge
		@(posedge clk);
		prog_we <= 1'b0;
		rst <= 1'b0;

		// outputs settle by the falling edge
		for (int i = 0; i < e_pc.size(); i++) begin
			@(negedge clk);
			check_record(i);
			@(posedge clk);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== verification/cpu_cases.mem ====
# P <byte address> <instruction word>
# E <pc> <hlt> <reg_wen> <reg_dst> <reg_wdata> <mem_wen> <mem_addr> <mem_wdata>
P 0000 a134
P 0002 b112
P 0004 a2ff
P 0006 b27f
P 0008 a301
P 000a a600
P 000c b680
P 000e 0413
P 0010 0523
P 0012 1933
P 0014 1763
P 0016 0a66
P 0018 2b12
P 001a 4c14
P 001c 5d64
P 001e 6e18
P 0020 6f13
P 0022 586f
P 0024 cc01
P 0026 a7aa
P 0028 c601
P 002a a7aa
P 002c c202
P 002e c402
P 0030 c802
P 0032 c001
P 0034 a7aa
P 0036 ca01
P 0038 a7aa
P 003a 0933
P 003c cc02
P 003e c602
P 0040 ca02
P 0042 c401
P 0044 a7aa
P 0046 c801
P 0048 a7aa
P 004a 4961
P 004c c002
P 004e c201
P 0050 a7aa
P 0052 c801
P 0054 a7aa
P 0056 ca01
P 0058 a7aa
P 005a c402
P 005c ce01
P 005e a7aa
P 0060 a940
P 0062 9192
P 0064 929e
P 0066 8a92
P 0068 8b9e
P 006a ec00
P 006c a074
P 006e de00
P 0070 a7aa
P 0072 a7aa
P 0074 3123
P 0076 7456
P 0078 f000
# byte loads build the operands
E 0000 0 1 1 0034 0 0000 0000
E 0002 0 1 1 1234 0 0000 0000
E 0004 0 1 2 00ff 0 0000 0000
E 0006 0 1 2 7fff 0 0000 0000
E 0008 0 1 3 0001 0 0000 0000
E 000a 0 1 6 0000 0 0000 0000
E 000c 0 1 6 8000 0 0000 0000
# add and sub, plain and saturated
E 000e 0 1 4 1235 0 0000 0000
E 0010 0 1 5 7fff 0 0000 0000
E 0012 0 1 9 0000 0 0000 0000
E 0014 0 1 7 8000 0 0000 0000
E 0016 0 1 a 8000 0 0000 0000
# xor and shifts leave v and n set
E 0018 0 1 b 6dcb 0 0000 0000
E 001a 0 1 c 2340 0 0000 0000
E 001c 0 1 d f800 0 0000 0000
E 001e 0 1 e 3412 0 0000 0000
E 0020 0 1 f 8246 0 0000 0000
E 0022 0 1 8 ffff 0 0000 0000
# branches with z0 v1 n1
E 0024 0 0 0 0000 0 0000 0000
E 0028 0 0 0 0000 0 0000 0000
E 002c 0 0 0 0000 0 0000 0000
E 002e 0 0 0 0000 0 0000 0000
E 0030 0 0 0 0000 0 0000 0000
E 0032 0 0 0 0000 0 0000 0000
E 0036 0 0 0 0000 0 0000 0000
# branches with z0 v0 n0
E 003a 0 1 9 0002 0 0000 0000
E 003c 0 0 0 0000 0 0000 0000
E 003e 0 0 0 0000 0 0000 0000
E 0040 0 0 0 0000 0 0000 0000
E 0042 0 0 0 0000 0 0000 0000
E 0046 0 0 0 0000 0 0000 0000
# branches with z1 v0 n0
E 004a 0 1 9 0000 0 0000 0000
E 004c 0 0 0 0000 0 0000 0000
E 004e 0 0 0 0000 0 0000 0000
E 0052 0 0 0 0000 0 0000 0000
E 0056 0 0 0 0000 0 0000 0000
E 005a 0 0 0 0000 0 0000 0000
E 005c 0 0 0 0000 0 0000 0000
# stores, loads, pcs and br
E 0060 0 1 9 0040 0 0000 0000
E 0062 0 0 0 0000 1 0044 1234
E 0064 0 0 0 0000 1 003c 7fff
E 0066 0 1 a 1234 0 0000 0000
E 0068 0 1 b 7fff 0 0000 0000
E 006a 0 1 c 006c 0 0000 0000
E 006c 0 1 0 0074 0 0000 0000
E 006e 0 0 0 0000 0 0000 0000
# reserved opcodes then halt
E 0074 0 0 0 0000 0 0000 0000
E 0076 0 0 0 0000 0 0000 0000
E 0078 1 0 0 0000 0 0000 0000
E 0078 1 0 0 0000 0 0000 0000
E 0078 1 0 0 0000 0 0000 0000
E 0078 1 0 0 0000 0 0000 0000
E 0078 1 0 0 0000 0 0000 0000
END

// ==== tb.f ====
common/cpu_pkg.sv
alu/alu.sv
hdl/memory.sv
hdl/register_file.sv
hdl/control_unit.sv
hdl/pc_control.sv
hdl/cpu.sv
verification/cpu_tb.sv

// ==== run.sh ====
#!/bin/bash
verilator --binary --timing --assert --top-module cpu_tb -f tb.f \
	&& ./obj_dir/Vcpu_tb | tee /dev/stderr | grep -qF "TEST RESULT: PASS" \
	|| { echo "simulation did not pass"; exit 1; }
